//--- source/debug_pkg.sv
package debug_pkg;

    //////////////////////////////////////////////////
    // Link and word widths
    //////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;   // One byte on the host link.
    typedef logic [31:0] instr_t;  // Instruction or state word.

    localparam int BYTES_PER_WORD = 4;
    localparam int PROG_ADDR_W    = 10;  // Program memory address width.

    localparam instr_t HALT_INSTRUCTION = 32'hFFFF_FFFF;

    //////////////////////////////////////////////////
    // Host command codes
    //////////////////////////////////////////////////

    localparam byte_t CMD_SOFT_RESET     = 8'h00;
    localparam byte_t CMD_RESET_DONE     = 8'h01;  // Reply and host confirmation.
    localparam byte_t CMD_RUN_CONTINUOUS = 8'h03;
    localparam byte_t CMD_RUN_STEP       = 8'h07;
    localparam byte_t ACK_PART3          = 8'h08;
    localparam byte_t ACK_PART2          = 8'h10;
    localparam byte_t ACK_PART1          = 8'h18;
    localparam byte_t ACK_PART0          = 8'h20;
    localparam byte_t MSG_DUMP_END       = 8'h0B;
    localparam byte_t ACK_DUMP_END       = 8'h28;

    // First state word sits two entries into the select space.
    localparam int DB_SELECT_BASE = 2;

    //////////////////////////////////////////////////
    // Controller state and port bundles
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        SOFT_RESET,
        REPLY_RESET,
        LOAD,
        WAIT_START,
        RUN,
        DUMP,
        DUMP_END
    } dbg_state_t;

    typedef struct packed {
        logic  strobe;  // One cycle per received byte.
        byte_t data;
    } rx_byte_t;

    typedef struct packed {
        logic  start;   // Held until the host acknowledges.
        byte_t data;
    } tx_byte_t;

    typedef struct packed {
        logic                   en;
        logic [PROG_ADDR_W-1:0] addr;
        instr_t                 data;
    } prog_write_t;

endpackage

//--- source/debug_fsm.sv
`timescale 1ns/10ps

module debug_fsm (
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_rx_done,
    input  logic              i_soft_reset_ack,
    input  logic              i_flag_halt,
    input  logic              i_halt_loaded,
    input  logic              i_dump_done,
    input  debug_pkg::byte_t    i_data_rx,
    input  debug_pkg::tx_byte_t i_dump_tx,
    output debug_pkg::rx_byte_t o_rx,
    output logic              o_loading,
    output logic              o_dump_start,
    output logic              o_soft_reset,
    output logic              o_exec_mode,
    output logic              o_enable_pc,
    output logic              o_enable_pipeline,
    output debug_pkg::tx_byte_t o_tx
);

    import debug_pkg::*;

    dbg_state_t state;
    dbg_state_t next_state;
    logic       rx_done_q;
    logic       rx_strobe;
    logic       exec_mode;    // 0 continuous, 1 single step.
    logic       run_first;    // High in the first cycle of RUN.
    logic       start_cmd;
    logic       run_enable;

    //////////////////////////////////////////////////
    // Received byte detection
    //////////////////////////////////////////////////

    assign rx_strobe = ~i_rx_done & rx_done_q;  // Falling edge of rx_done.

    assign o_rx.strobe = rx_strobe;
    assign o_rx.data   = i_data_rx;

    assign start_cmd = (state == WAIT_START) && rx_strobe &&
                       ((i_data_rx == CMD_RUN_CONTINUOUS) || (i_data_rx == CMD_RUN_STEP));

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state     <= IDLE;
            rx_done_q <= 1'b0;
            exec_mode <= 1'b0;
            run_first <= 1'b0;
        end else begin
            state     <= next_state;
            rx_done_q <= i_rx_done;
            run_first <= (state != RUN) && (next_state == RUN);
            if (start_cmd) begin
                exec_mode <= i_data_rx[2];  // Bit 2 tells step from continuous.
            end
        end
    end

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (rx_strobe && (i_data_rx == CMD_SOFT_RESET)) begin
                    next_state = SOFT_RESET;
                end
            end
            SOFT_RESET: begin
                if (!i_soft_reset_ack) begin
                    next_state = REPLY_RESET;  // Processor has seen the reset.
                end
            end
            REPLY_RESET: begin
                if (rx_strobe && (i_data_rx == CMD_RESET_DONE)) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                if (i_halt_loaded) begin
                    next_state = WAIT_START;
                end
            end
            WAIT_START: begin
                if (start_cmd) begin
                    next_state = RUN;
                end
            end
            RUN: begin
                if (exec_mode || i_flag_halt) begin
                    next_state = DUMP;
                end
            end
            DUMP: begin
                if (i_dump_done) begin
                    next_state = DUMP_END;
                end
            end
            DUMP_END: begin
                if (rx_strobe && (i_data_rx == ACK_DUMP_END)) begin
                    // A step that has not reached HALT goes back for another start.
                    if (exec_mode && !i_flag_halt) begin
                        next_state = WAIT_START;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    // Single step runs only in the first cycle; continuous runs until HALT.
    assign run_enable = (state == RUN) && (exec_mode ? run_first : !i_flag_halt);

    assign o_enable_pc       = run_enable;
    assign o_enable_pipeline = run_enable;  // Same edge as the PC.
    assign o_soft_reset      = (state != SOFT_RESET);  // Active low.
    assign o_loading         = (state == LOAD);
    assign o_dump_start      = (state == RUN) && (next_state == DUMP);
    assign o_exec_mode       = exec_mode;

    always_comb begin
        case (state)
            REPLY_RESET: begin
                o_tx.start = 1'b1;
                o_tx.data  = CMD_RESET_DONE;
            end
            DUMP: begin
                o_tx = i_dump_tx;  // Sender owns the link here.
            end
            DUMP_END: begin
                o_tx.start = 1'b1;
                o_tx.data  = MSG_DUMP_END;
            end
            default: begin
                o_tx.start = 1'b0;
                o_tx.data  = '0;
            end
        endcase
    end

endmodule

//--- source/program_loader.sv
`timescale 1ns/10ps

module program_loader (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_loading,
    input  debug_pkg::rx_byte_t   i_rx,
    output debug_pkg::prog_write_t o_prog_write,
    output logic                  o_halt_loaded
);

    import debug_pkg::*;

    localparam int COUNT_W = $clog2(BYTES_PER_WORD);

    logic [COUNT_W-1:0]     byte_count;
    logic [PROG_ADDR_W-1:0] write_addr;
    instr_t                 word;
    instr_t                 assembled;
    logic                   word_done;

    // New byte enters at the bottom, so the first one ends up as the MSB.
    assign assembled = {word[23:0], i_rx.data};
    assign word_done = i_loading && i_rx.strobe &&
                       (byte_count == COUNT_W'(BYTES_PER_WORD - 1));

    //////////////////////////////////////////////////
    // Byte count, address and write strobes
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            byte_count      <= '0;
            write_addr      <= '0;
            o_prog_write.en <= 1'b0;
            o_halt_loaded   <= 1'b0;
        end else begin
            o_prog_write.en <= word_done;  // One cycle per finished word.
            o_halt_loaded   <= word_done && (assembled == HALT_INSTRUCTION);
            if (word_done) begin
                o_prog_write.addr <= write_addr;
                o_prog_write.data <= assembled;
            end
            if (!i_loading) begin
                byte_count <= '0;
                write_addr <= '0;
            end else if (i_rx.strobe) begin
                byte_count <= byte_count + 1'b1;  // Wraps every word.
                if (word_done) begin
                    write_addr <= write_addr + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Word assembly
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_loading) begin
            word <= '0;
        end else if (i_rx.strobe) begin
            word <= assembled;
        end
    end

endmodule

//--- source/register_dump_sender.sv
`timescale 1ns/10ps

module register_dump_sender #(
    parameter int DB_WORDS = 12,
    parameter int DB_SEL_W = 4
) (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_start,
    input  debug_pkg::rx_byte_t i_rx,
    input  debug_pkg::instr_t   i_db_word,
    output debug_pkg::tx_byte_t o_tx,
    output logic [DB_SEL_W-1:0] o_db_select,
    output logic                o_done
);

    import debug_pkg::*;

    logic                busy;
    logic [1:0]          part;      // Byte of the word, 3 first.
    logic [DB_SEL_W-1:0] word_idx;
    byte_t               ack_code;
    logic                ack_ok;
    logic                last_word;

    // Each byte has its own acknowledge code.
    always_comb begin
        case (part)
            2'd3:    ack_code = ACK_PART3;
            2'd2:    ack_code = ACK_PART2;
            2'd1:    ack_code = ACK_PART1;
            default: ack_code = ACK_PART0;
        endcase
    end

    assign ack_ok    = busy && i_rx.strobe && (i_rx.data == ack_code);
    assign last_word = (word_idx == DB_SEL_W'(DB_WORDS - 1));
    assign o_done    = ack_ok && (part == 2'd0) && last_word;

    //////////////////////////////////////////////////
    // Part and word sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            busy     <= 1'b0;
            part     <= 2'd3;
            word_idx <= '0;
        end else if (i_start) begin
            busy     <= 1'b1;
            part     <= 2'(BYTES_PER_WORD - 1);
            word_idx <= '0;
        end else if (ack_ok) begin
            part <= part - 1'b1;  // 0 wraps to 3 for the next word.
            if (part == 2'd0) begin
                if (last_word) begin
                    busy <= 1'b0;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Link byte and word select
    //////////////////////////////////////////////////

    assign o_tx.start  = busy;
    assign o_tx.data   = busy ? i_db_word[8*part +: 8] : '0;
    assign o_db_select = busy ? word_idx + DB_SEL_W'(DB_SELECT_BASE) : '0;

endmodule

//--- source/debug_unit.sv
`timescale 1ns/10ps

module debug_unit #(
    parameter  int DB_WORDS = 12,
    localparam int DB_SEL_W = $clog2(DB_WORDS + debug_pkg::DB_SELECT_BASE)
) (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_rx_done,
    input  logic                   i_soft_reset_ack,
    input  logic                   i_flag_halt,
    input  debug_pkg::byte_t       i_data_rx,
    input  debug_pkg::instr_t      i_db_word,
    output debug_pkg::tx_byte_t    o_tx,
    output logic                   o_soft_reset,
    output logic                   o_exec_mode,
    output logic                   o_enable_pc,
    output logic                   o_enable_pipeline,
    output debug_pkg::prog_write_t o_prog_write,
    output logic [DB_SEL_W-1:0]    o_db_select
);

    import debug_pkg::*;

    rx_byte_t rx;
    tx_byte_t dump_tx;
    logic     loading;
    logic     halt_loaded;
    logic     dump_start;
    logic     dump_done;

    debug_fsm u_fsm (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_soft_reset_ack  (i_soft_reset_ack),
        .i_flag_halt       (i_flag_halt),
        .i_halt_loaded     (halt_loaded),
        .i_dump_done       (dump_done),
        .i_data_rx         (i_data_rx),
        .i_dump_tx         (dump_tx),
        .o_rx              (rx),
        .o_loading         (loading),
        .o_dump_start      (dump_start),
        .o_soft_reset      (o_soft_reset),
        .o_exec_mode       (o_exec_mode),
        .o_enable_pc       (o_enable_pc),
        .o_enable_pipeline (o_enable_pipeline),
        .o_tx              (o_tx)
    );

    program_loader u_loader (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_loading     (loading),
        .i_rx          (rx),
        .o_prog_write  (o_prog_write),
        .o_halt_loaded (halt_loaded)
    );

    register_dump_sender #(
        .DB_WORDS (DB_WORDS),
        .DB_SEL_W (DB_SEL_W)
    ) u_sender (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_start     (dump_start),
        .i_rx        (rx),
        .i_db_word   (i_db_word),
        .o_tx        (dump_tx),
        .o_db_select (o_db_select),
        .o_done      (dump_done)
    );

endmodule

//--- test/debug_unit_chk.sv
`timescale 1ns/10ps

module debug_unit_chk (
    input logic                   i_clock,
    input logic                   i_reset,
    input debug_pkg::tx_byte_t    i_tx,
    input logic                   i_soft_reset,
    input logic                   i_exec_mode,
    input logic                   i_enable_pc,
    input logic                   i_enable_pipeline,
    input debug_pkg::prog_write_t i_prog_write
);

    logic any_enable;

    assign any_enable = i_enable_pc || i_enable_pipeline;

    //////////////////////////////////////////////////
    // Enables against link and soft reset
    //////////////////////////////////////////////////

    enable_quiet_on_tx: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_tx.start |-> !any_enable)
        else $error("Processor enabled while a byte waits on the link.");

    enable_quiet_in_reset: assert property (@(posedge i_clock) disable iff (!i_reset)
        !i_soft_reset |-> !any_enable)
        else $error("Processor enabled during soft reset.");

    //////////////////////////////////////////////////
    // Write and step pulses
    //////////////////////////////////////////////////

    write_single_cycle: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_prog_write.en |=> !i_prog_write.en)
        else $error("Program write enable held for two cycles.");

    step_single_cycle: assert property (@(posedge i_clock) disable iff (!i_reset)
        (i_exec_mode && i_enable_pc) |=> !i_enable_pc)
        else $error("Single step enabled the PC for two cycles.");

endmodule

bind debug_unit debug_unit_chk u_chk (
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_tx              (o_tx),
    .i_soft_reset      (o_soft_reset),
    .i_exec_mode       (o_exec_mode),
    .i_enable_pc       (o_enable_pc),
    .i_enable_pipeline (o_enable_pipeline),
    .i_prog_write      (o_prog_write)
);

//--- test/debug_unit_tb.sv
`timescale 1ns/10ps

module debug_unit_tb;

    import debug_pkg::*;

    localparam int DB_WORDS    = 5;
    localparam int SEL_W       = $clog2(DB_WORDS + DB_SELECT_BASE);
    localparam int RUN_CYCLES  = 8;   // Continuous cycles before HALT.
    localparam int SEND_CYCLES = 2;
    localparam int LOAD_CYCLES = 5 * BYTES_PER_WORD * SEND_CYCLES + 2;
    localparam int DUMP_CYCLES = (DB_WORDS * BYTES_PER_WORD + 3) * SEND_CYCLES + 2;
    localparam int HANDSHAKE_CYCLES = 2 * SEND_CYCLES + 6;
    localparam int CYCLE_LIMIT = 16 + 2 * LOAD_CYCLES + 4 * DUMP_CYCLES
                                 + 2 * HANDSHAKE_CYCLES + 8 * SEND_CYCLES
                                 + RUN_CYCLES + 100;

    logic              clock;
    logic              reset;
    logic              rx_done;
    logic              soft_reset_ack;
    logic              flag_halt;
    byte_t             data_rx;
    instr_t            db_word;
    tx_byte_t          tx;
    logic              soft_reset;
    logic              exec_mode;
    logic              enable_pc;
    logic              enable_pipeline;
    prog_write_t       prog_write;
    logic [SEL_W-1:0]  db_select;

    int cycle_count = 0;
    int write_count = 0;
    int pc_count    = 0;
    int error_count = 0;
    int test_errors = 0;
    int tests_run   = 0;

    debug_unit #(.DB_WORDS(DB_WORDS)) dut (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_rx_done         (rx_done),
        .i_soft_reset_ack  (soft_reset_ack),
        .i_flag_halt       (flag_halt),
        .i_data_rx         (data_rx),
        .i_db_word         (db_word),
        .o_tx              (tx),
        .o_soft_reset      (soft_reset),
        .o_exec_mode       (exec_mode),
        .o_enable_pc       (enable_pc),
        .o_enable_pipeline (enable_pipeline),
        .o_prog_write      (prog_write),
        .o_db_select       (db_select)
    );

    // Processor state word model, every byte known from the select.
    assign db_word = 32'hA500_0000 + instr_t'(db_select) * 32'h0001_0203;

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (prog_write.en) write_count <= write_count + 1;
        if (enable_pc) pc_count <= pc_count + 1;
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic report_error(string msg);
        $display("Error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_byte(byte_t actual, byte_t expected, string what);
        if (actual !== expected)
            report_error($sformatf("%s is 0x%h, expected 0x%h", what, actual, expected));
    endtask

    task automatic compare_bit(logic actual, logic expected, string what);
        if (actual !== expected)
            report_error($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    task automatic compare_write(prog_write_t actual, prog_write_t expected, string what);
        if (actual !== expected)
            report_error($sformatf("%s is 0x%h, expected 0x%h", what, actual, expected));
    endtask

    task automatic compare_count(int actual, int expected, string what);
        if (actual != expected)
            report_error($sformatf("%s is %0d, expected %0d", what, actual, expected));
    endtask

    task automatic finish_test(string name);
        tests_run++;
        $display("Test %s finished with %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    //////////////////////////////////////////////////
    // Host model
    //////////////////////////////////////////////////

    // Returns one cycle after the DUT has taken the byte.
    task automatic send_byte(byte_t value);
        data_rx = value;
        rx_done = 1'b1;
        @(posedge clock);
        #2 rx_done = 1'b0;
        @(posedge clock);
        #2;
    endtask

    function automatic byte_t ack_code_for(int part);
        case (part)
            3:       return ACK_PART3;
            2:       return ACK_PART2;
            1:       return ACK_PART1;
            default: return ACK_PART0;
        endcase
    endfunction

    task automatic soft_reset_handshake();
        send_byte(CMD_SOFT_RESET);
        compare_bit(soft_reset, 1'b0, "soft reset");
        repeat (3) @(posedge clock);
        #2 compare_bit(soft_reset, 1'b0, "held soft reset");
        soft_reset_ack = 1'b0;
        @(posedge clock);
        #2 soft_reset_ack = 1'b1;
        compare_bit(soft_reset, 1'b1, "released soft reset");
        compare_bit(tx.start, 1'b1, "reply start");
        compare_byte(tx.data, CMD_RESET_DONE, "reply byte");
        send_byte(CMD_RESET_DONE);
        compare_bit(tx.start, 1'b0, "start in load");
    endtask

    task automatic load_program();
        instr_t      words[5];
        prog_write_t expected;
        int          base;
        base = write_count;
        for (int i = 0; i < 4; i++) begin
            words[i] = $urandom();
            if (words[i] == HALT_INSTRUCTION) words[i] = '0;
        end
        words[4] = HALT_INSTRUCTION;
        for (int i = 0; i < 5; i++) begin
            for (int b = BYTES_PER_WORD - 1; b >= 0; b--) send_byte(words[i][8*b +: 8]);
            expected.en   = 1'b1;
            expected.addr = PROG_ADDR_W'(i);
            expected.data = words[i];
            compare_write(prog_write, expected, "program write");
        end
        @(posedge clock);
        #2 compare_count(write_count - base, 5, "program write count");
    endtask

    task automatic check_dump_byte(int k, int part);
        instr_t word;
        word = 32'hA500_0000 + instr_t'(k + DB_SELECT_BASE) * 32'h0001_0203;
        compare_bit(tx.start, 1'b1, "dump start");
        compare_byte(tx.data, word[8*part +: 8], "dump byte");
        compare_byte(byte_t'(db_select), byte_t'(k + DB_SELECT_BASE), "state word select");
    endtask

    task automatic receive_dump(bit wrong_acks);
        for (int k = 0; k < DB_WORDS; k++) begin
            for (int part = BYTES_PER_WORD - 1; part >= 0; part--) begin
                check_dump_byte(k, part);
                if (wrong_acks && k == 1 && part == 2) begin
                    send_byte(8'h55);
                    check_dump_byte(k, part);
                    send_byte(ack_code_for(part - 1));  // Code of the next part.
                    check_dump_byte(k, part);
                end
                send_byte(ack_code_for(part));
            end
        end
        compare_bit(tx.start, 1'b1, "end marker start");
        compare_byte(tx.data, MSG_DUMP_END, "end marker");
        send_byte(ACK_DUMP_END);
        compare_bit(tx.start, 1'b0, "start after dump");
    endtask

    task automatic single_step(bit wrong_acks);
        int base;
        base = pc_count;
        send_byte(CMD_RUN_STEP);
        compare_bit(exec_mode, 1'b1, "exec mode");
        @(posedge clock);
        #2 compare_count(pc_count - base, 1, "step PC enables");
        receive_dump(wrong_acks);
        compare_count(pc_count - base, 1, "PC enables after step dump");
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        compare_bit(tx.start, 1'b0, "tx start");
        compare_byte(tx.data, 8'h00, "tx data");
        compare_bit(soft_reset, 1'b1, "soft reset");
        compare_bit(prog_write.en, 1'b0, "write enable");
        compare_bit(enable_pc, 1'b0, "PC enable");
        compare_bit(enable_pipeline, 1'b0, "pipeline enable");
        compare_bit(exec_mode, 1'b0, "exec mode");
        compare_byte(byte_t'(db_select), 8'h00, "state word select");
        finish_test("reset");
    endtask

    task automatic test_continuous();
        int base;
        send_byte(CMD_RUN_CONTINUOUS);
        compare_bit(exec_mode, 1'b0, "exec mode");
        base = pc_count;
        repeat (RUN_CYCLES) begin
            compare_bit(enable_pc, 1'b1, "PC enable");
            compare_bit(enable_pipeline, 1'b1, "pipeline enable");
            @(posedge clock);
            #2;
        end
        flag_halt = 1'b1;
        #1 compare_bit(enable_pc, 1'b0, "PC enable at HALT");
        compare_bit(enable_pipeline, 1'b0, "pipeline enable at HALT");
        @(posedge clock);
        #2 compare_count(pc_count - base, RUN_CYCLES, "continuous PC enables");
        receive_dump(1'b0);
        flag_halt = 1'b0;
        soft_reset_handshake();  // Back in IDLE, so 0x00 works again.
        finish_test("continuous run and dump");
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b0;
        rx_done        = 1'b0;
        soft_reset_ack = 1'b1;
        flag_halt      = 1'b0;
        data_rx        = '0;
        void'($urandom(77));
        repeat (16) @(posedge clock);
        #2 reset = 1'b1;
        test_reset();
        soft_reset_handshake();
        finish_test("soft reset and reply");
        load_program();
        finish_test("program loading");
        test_continuous();
        load_program();
        single_step(1'b0);
        single_step(1'b0);
        finish_test("single step");
        single_step(1'b1);
        finish_test("wrong acknowledge");
        $display("Tests run: %0d, errors: %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- project.f
source/debug_pkg.sv
source/debug_fsm.sv
source/program_loader.sv
source/register_dump_sender.sv
source/debug_unit.sv
test/debug_unit_chk.sv
test/debug_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module debug_unit_tb \
    -f project.f -o sim_debug_unit

./obj_dir/sim_debug_unit | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
